//--- src/arm_defs.svh
`ifndef ARM_DEFS_SVH
`define ARM_DEFS_SVH

// Data and address width
`define WORD_W 32

// Register number width, R0 to R15
`define REG_AW 4

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

//--- src/armPkg.sv
`include "arm_defs.svh"

package armPkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [`REG_AW-1:0] regAddr_t;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluPassB
  } aluOp_t;

  // Same bit order as the CPSR top nibble
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  typedef enum logic [1:0] {
    fwdNone      = 2'b00,
    fwdWriteback = 2'b01,
    fwdMemory    = 2'b10
  } fwdSel_t;

  // Control word entering Execute
  typedef struct packed {
    aluOp_t     aluOp;
    logic       aluSrcImm;
    logic       setFlags;
    logic       branch;
    logic [3:0] cond;
    logic       memWrite;
    logic       memToReg;
    logic       regWrite;
  } ctrlE_t;

  typedef struct packed {
    logic memWrite;
    logic memToReg;
    logic regWrite;
  } ctrlM_t;

  typedef struct packed {
    logic memToReg;
    logic regWrite;
  } ctrlW_t;

endpackage

//--- src/hazardIf.sv
`timescale 1ns/1ps

interface hazardIf (
  input logic clk,
  input logic reset
);

  // Register number comparisons from the datapath
  logic match1EM;
  logic match1EW;
  logic match2EM;
  logic match2EW;
  logic match12DE;

  // Pipeline control state from the controller
  logic memToRegE;
  logic regWriteM;
  logic regWriteW;
  logic branchTakenE;

  armPkg::fwdSel_t forwardAE;
  armPkg::fwdSel_t forwardBE;
  logic stallF;
  logic stallD;
  logic flushD;
  logic flushE;

  modport datapath (
    output match1EM, match1EW, match2EM, match2EW, match12DE,
    input  forwardAE, forwardBE, stallF, stallD, flushD
  );

  modport controller (
    output memToRegE, regWriteM, regWriteW, branchTakenE,
    input  flushE
  );

  modport hazard (
    input  clk, reset,
    input  match1EM, match1EW, match2EM, match2EW, match12DE,
    input  memToRegE, regWriteM, regWriteW, branchTakenE,
    output forwardAE, forwardBE, stallF, stallD, flushD, flushE
  );

endinterface

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic             clk,
  input  logic             writeEnable,
  input  armPkg::regAddr_t readAddr1,
  input  armPkg::regAddr_t readAddr2,
  input  armPkg::regAddr_t writeAddr,
  input  armPkg::word_t    writeData,
  input  armPkg::word_t    pcPlus8,
  output armPkg::word_t    readData1,
  output armPkg::word_t    readData2
);

  // R0 to R14 only, R15 is the PC
  armPkg::word_t regs [0:14];

  // Falling edge write so Decode sees the Writeback value in the same cycle
  always_ff @(negedge clk) begin
    if (writeEnable) begin
      regs[writeAddr] <= writeData;
    end
  end

  assign readData1 = (readAddr1 == '1) ? pcPlus8 : regs[readAddr1];
  assign readData2 = (readAddr2 == '1) ? pcPlus8 : regs[readAddr2];

  // Decoder turns every R15 destination into a bubble
  noPcWrite: assert property (@(negedge clk) writeEnable |-> (writeAddr != '1))
    else $error("regFile: write to R15");

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
  input  armPkg::word_t  srcA,
  input  armPkg::word_t  srcB,
  input  armPkg::aluOp_t op,
  output armPkg::word_t  result,
  output armPkg::flags_t flags
);

  localparam int W = $bits(armPkg::word_t);

  logic          isSub;
  logic          isArith;
  armPkg::word_t addB;
  logic [W:0]    sum;

  assign isSub   = (op == armPkg::aluSub);
  assign isArith = (op == armPkg::aluAdd) || isSub;

  // Subtract as A + ~B + 1, carry out is then NOT borrow
  assign addB = isSub ? ~srcB : srcB;
  assign sum  = {1'b0, srcA} + {1'b0, addB} + {{W{1'b0}}, isSub};

  always_comb begin
    case (op)
      armPkg::aluAdd,
      armPkg::aluSub:   result = sum[W-1:0];
      armPkg::aluAnd:   result = srcA & srcB;
      armPkg::aluOrr:   result = srcA | srcB;
      armPkg::aluPassB: result = srcB;
      default:          result = '0;
    endcase
  end

  // Logical ops leave C and V clear
  assign flags = '{
    n: result[W-1],
    z: (result == '0),
    c: isArith && sum[W],
    v: isArith && (srcA[W-1] == addB[W-1]) && (sum[W-1] != srcA[W-1])
  };

endmodule

//--- src/controller.sv
`timescale 1ns/1ps

module controller (
  input  logic           clk,
  input  logic           reset,
  input  armPkg::word_t  instrD,
  input  armPkg::flags_t flagsE,
  output logic [1:0]     regSrcD,
  output logic [1:0]     immSrcD,
  output armPkg::aluOp_t aluOpE,
  output logic           aluSrcImmE,
  output logic           memWriteM,
  output logic           memToRegW,
  output logic           regWriteW,
  output logic           branchTakenE,
  hazardIf.controller    hz
);

  localparam logic [3:0] condEq = 4'b0000;
  localparam logic [3:0] condNe = 4'b0001;
  localparam logic [3:0] condAl = 4'b1110;

  armPkg::ctrlE_t ctrlD;
  armPkg::ctrlE_t ctrlE;
  armPkg::ctrlM_t ctrlM;
  armPkg::ctrlW_t ctrlW;
  armPkg::flags_t flagsReg;
  armPkg::aluOp_t dpOpD;
  logic           dpKnownD;
  logic           isAlD;
  logic           isCmpD;
  logic           isMovD;
  logic           dpLegalD;
  logic           memLegalD;
  logic           brLegalD;
  logic           condPassE;

  assign isAlD  = (instrD[31:28] == condAl);
  assign isCmpD = (instrD[24:21] == 4'b1010);
  assign isMovD = (instrD[24:21] == 4'b1101);

  always_comb begin
    dpKnownD = 1'b1;
    dpOpD    = armPkg::aluAdd;
    case (instrD[24:21])
      4'b0100: dpOpD = armPkg::aluAdd;
      4'b0010: dpOpD = armPkg::aluSub;
      4'b1010: dpOpD = armPkg::aluSub;
      4'b0000: dpOpD = armPkg::aluAnd;
      4'b1100: dpOpD = armPkg::aluOrr;
      4'b1101: dpOpD = armPkg::aluPassB;
      default: dpKnownD = 1'b0;
    endcase
  end

  // Unshifted register or immediate, CMP needs S, MOV is immediate only, no R15 dest
  assign dpLegalD = isAlD && dpKnownD && (instrD[25] || instrD[11:4] == 8'h00) &&
                    (!isCmpD || instrD[20]) && (!isMovD || instrD[25]) &&
                    (isCmpD || instrD[15:12] != 4'hF);
  // Word access, pre-indexed, positive offset, no writeback
  assign memLegalD = isAlD && (instrD[25:21] == 5'b01100) &&
                     (!instrD[20] || instrD[15:12] != 4'hF);
  assign brLegalD  = (instrD[25:24] == 2'b10) &&
                     (instrD[31:28] == condAl || instrD[31:28] == condEq ||
                      instrD[31:28] == condNe);

  // Anything not recognised leaves ctrlD as a bubble
  always_comb begin
    ctrlD   = '0;
    regSrcD = 2'b00;
    immSrcD = 2'b00;
    case (instrD[27:26])
      2'b00: begin
        if (dpLegalD) begin
          ctrlD.aluOp     = dpOpD;
          ctrlD.aluSrcImm = instrD[25];
          ctrlD.setFlags  = instrD[20];
          ctrlD.regWrite  = !isCmpD;
        end
      end
      2'b01: begin
        // Stores read Rd on the second port
        regSrcD = {!instrD[20], 1'b0};
        immSrcD = 2'b01;
        if (memLegalD) begin
          ctrlD.aluSrcImm = 1'b1;
          ctrlD.memWrite  = !instrD[20];
          ctrlD.memToReg  = instrD[20];
          ctrlD.regWrite  = instrD[20];
        end
      end
      2'b10: begin
        regSrcD = 2'b01;
        immSrcD = 2'b10;
        if (brLegalD) begin
          ctrlD.aluSrcImm = 1'b1;
          ctrlD.branch    = 1'b1;
          ctrlD.cond      = instrD[31:28];
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || hz.flushE) begin
      ctrlE <= '0;
    end else begin
      ctrlE <= ctrlD;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrlM <= '0;
      ctrlW <= '0;
    end else begin
      ctrlM <= '{memWrite: ctrlE.memWrite, memToReg: ctrlE.memToReg,
                 regWrite: ctrlE.regWrite};
      ctrlW <= '{memToReg: ctrlM.memToReg, regWrite: ctrlM.regWrite};
    end
  end

  // NZCV, written at the end of Execute
  always_ff @(posedge clk) begin
    if (reset) begin
      flagsReg <= '0;
    end else if (ctrlE.setFlags) begin
      flagsReg <= flagsE;
    end
  end

  always_comb begin
    case (ctrlE.cond)
      condAl:  condPassE = 1'b1;
      condEq:  condPassE = flagsReg.z;
      condNe:  condPassE = !flagsReg.z;
      default: condPassE = 1'b0;
    endcase
  end

  assign branchTakenE = ctrlE.branch && condPassE;

  assign aluOpE     = ctrlE.aluOp;
  assign aluSrcImmE = ctrlE.aluSrcImm;
  assign memWriteM  = ctrlM.memWrite;
  assign memToRegW  = ctrlW.memToReg;
  assign regWriteW  = ctrlW.regWrite;

  assign hz.memToRegE    = ctrlE.memToReg;
  assign hz.regWriteM    = ctrlM.regWrite;
  assign hz.regWriteW    = ctrlW.regWrite;
  assign hz.branchTakenE = branchTakenE;

  // Both wrong-path slots behind a taken branch reach Execute as bubbles
  branchShadow: assert property (@(posedge clk) disable iff (reset)
    branchTakenE |=> (ctrlE == '0) [*2])
    else $error("controller: live instruction behind taken branch");

endmodule

//--- src/datapath.sv
`timescale 1ns/1ps
`include "arm_defs.svh"

module datapath (
  input  logic             clk,
  input  logic             reset,
  output armPkg::word_t    pcF,
  input  armPkg::word_t    instrF,
  output armPkg::word_t    instrD,
  input  logic [1:0]       regSrcD,
  input  logic [1:0]       immSrcD,
  input  armPkg::aluOp_t   aluOpE,
  input  logic             aluSrcImmE,
  input  logic             memToRegW,
  input  logic             regWriteW,
  input  logic             branchTakenE,
  output armPkg::flags_t   flagsE,
  output armPkg::word_t    aluOutM,
  output armPkg::word_t    writeDataM,
  input  armPkg::word_t    readDataM,
  hazardIf.datapath        hz
);

  armPkg::word_t        pcPlus4F;
  armPkg::word_t        pcNextF;
  armPkg::word_t        pcPlus8D;
  armPkg::word_t        rd1D;
  armPkg::word_t        rd2D;
  armPkg::word_t        imm8D;
  armPkg::word_t        extImmD;
  logic [4:0]           rotAmtD;
  logic [2*`WORD_W-1:0] rotPairD;
  armPkg::regAddr_t     ra1D;
  armPkg::regAddr_t     ra2D;
  armPkg::regAddr_t     wa3D;
  armPkg::word_t        rd1E;
  armPkg::word_t        rd2E;
  armPkg::word_t        extImmE;
  armPkg::word_t        srcAE;
  armPkg::word_t        srcBE;
  armPkg::word_t        writeDataE;
  armPkg::word_t        aluResultE;
  armPkg::regAddr_t     ra1E;
  armPkg::regAddr_t     ra2E;
  armPkg::regAddr_t     wa3E;
  armPkg::regAddr_t     wa3M;
  armPkg::regAddr_t     wa3W;
  armPkg::word_t        aluOutW;
  armPkg::word_t        readDataW;
  armPkg::word_t        resultW;

  // Fetch
  assign pcPlus4F = pcF + 4;
  assign pcNextF  = branchTakenE ? aluResultE : pcPlus4F;

  always_ff @(posedge clk) begin
    if (reset) begin
      pcF <= `RESET_PC;
    end else if (!hz.stallF) begin
      pcF <= pcNextF;
    end
  end

  // Decode, all-zero word decodes as a bubble
  always_ff @(posedge clk) begin
    if (reset || hz.flushD) begin
      instrD <= '0;
    end else if (!hz.stallD) begin
      instrD <= instrF;
    end
  end

  // Fetch is one word ahead, so PC+4 of fetch is PC+8 of decode
  assign pcPlus8D = pcPlus4F;

  assign ra1D = regSrcD[0] ? '1 : instrD[19:16];
  assign ra2D = regSrcD[1] ? instrD[15:12] : instrD[3:0];
  assign wa3D = instrD[15:12];

  regFile i_regFile (
    .clk        (clk),
    .writeEnable(regWriteW),
    .readAddr1  (ra1D),
    .readAddr2  (ra2D),
    .writeAddr  (wa3W),
    .writeData  (resultW),
    .pcPlus8    (pcPlus8D),
    .readData1  (rd1D),
    .readData2  (rd2D)
  );

  // imm8 rotated right by twice the rotate field
  assign imm8D    = armPkg::word_t'(instrD[7:0]);
  assign rotAmtD  = {instrD[11:8], 1'b0};
  assign rotPairD = {imm8D, imm8D} >> rotAmtD;

  always_comb begin
    case (immSrcD)
      2'b00:   extImmD = rotPairD[`WORD_W-1:0];
      2'b01:   extImmD = armPkg::word_t'(instrD[11:0]);
      default: extImmD = {{(`WORD_W-26){instrD[23]}}, instrD[23:0], 2'b00};
    endcase
  end

  // Execute
  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    extImmE <= extImmD;
    ra1E    <= ra1D;
    ra2E    <= ra2D;
    wa3E    <= wa3D;
  end

  always_comb begin
    case (hz.forwardAE)
      armPkg::fwdMemory:    srcAE = aluOutM;
      armPkg::fwdWriteback: srcAE = resultW;
      default:              srcAE = rd1E;
    endcase
    case (hz.forwardBE)
      armPkg::fwdMemory:    writeDataE = aluOutM;
      armPkg::fwdWriteback: writeDataE = resultW;
      default:              writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcImmE ? extImmE : writeDataE;

  alu i_alu (
    .srcA  (srcAE),
    .srcB  (srcBE),
    .op    (aluOpE),
    .result(aluResultE),
    .flags (flagsE)
  );

  // Memory
  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    wa3M       <= wa3E;
  end

  // Writeback
  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readDataM;
    wa3W      <= wa3M;
  end

  assign resultW = memToRegW ? readDataW : aluOutW;

  // Destination versus source comparisons for the hazard unit
  assign hz.match1EM  = (ra1E == wa3M);
  assign hz.match1EW  = (ra1E == wa3W);
  assign hz.match2EM  = (ra2E == wa3M);
  assign hz.match2EW  = (ra2E == wa3W);
  assign hz.match12DE = (wa3E == ra1D) || (wa3E == ra2D);

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
  hazardIf.hazard hz
);

  logic loadUseD;

  // Memory holds the younger result, so it wins over Writeback
  function automatic armPkg::fwdSel_t pickForward(
    input logic matchM,
    input logic matchW,
    input logic regWriteM,
    input logic regWriteW
  );
    if (matchM && regWriteM) begin
      return armPkg::fwdMemory;
    end else if (matchW && regWriteW) begin
      return armPkg::fwdWriteback;
    end
    return armPkg::fwdNone;
  endfunction

  always_comb begin
    hz.forwardAE = pickForward(hz.match1EM, hz.match1EW, hz.regWriteM, hz.regWriteW);
    hz.forwardBE = pickForward(hz.match2EM, hz.match2EW, hz.regWriteM, hz.regWriteW);
  end

  // Load in Execute feeding the instruction in Decode
  assign loadUseD = hz.memToRegE && hz.match12DE;

  assign hz.stallF = loadUseD;
  assign hz.stallD = loadUseD;
  assign hz.flushD = hz.branchTakenE;
  // Bubble for the load-use hold, wrong path for a taken branch
  assign hz.flushE = loadUseD || hz.branchTakenE;

  // Load and branch can never sit in Execute together
  stallFlushExcl: assert property (@(posedge hz.clk) disable iff (hz.reset)
    !(hz.stallD && hz.flushD))
    else $error("hazardUnit: Decode stalled and flushed in the same cycle");

endmodule

//--- src/armCore.sv
`timescale 1ns/1ps

module armCore (
  input  logic          clk,
  input  logic          reset,
  output armPkg::word_t pcF,
  input  armPkg::word_t instrF,
  output logic          memWrite,
  output armPkg::word_t aluOutM,
  output armPkg::word_t writeDataM,
  input  armPkg::word_t readDataM
);

  armPkg::word_t  instrD;
  armPkg::flags_t flagsE;
  logic [1:0]     regSrcD;
  logic [1:0]     immSrcD;
  armPkg::aluOp_t aluOpE;
  logic           aluSrcImmE;
  logic           memToRegW;
  logic           regWriteW;
  logic           branchTakenE;

  hazardIf hz (
    .clk  (clk),
    .reset(reset)
  );

  controller i_controller (
    .clk         (clk),
    .reset       (reset),
    .instrD      (instrD),
    .flagsE      (flagsE),
    .regSrcD     (regSrcD),
    .immSrcD     (immSrcD),
    .aluOpE      (aluOpE),
    .aluSrcImmE  (aluSrcImmE),
    .memWriteM   (memWrite),
    .memToRegW   (memToRegW),
    .regWriteW   (regWriteW),
    .branchTakenE(branchTakenE),
    .hz          (hz.controller)
  );

  datapath i_datapath (
    .clk         (clk),
    .reset       (reset),
    .pcF         (pcF),
    .instrF      (instrF),
    .instrD      (instrD),
    .regSrcD     (regSrcD),
    .immSrcD     (immSrcD),
    .aluOpE      (aluOpE),
    .aluSrcImmE  (aluSrcImmE),
    .memToRegW   (memToRegW),
    .regWriteW   (regWriteW),
    .branchTakenE(branchTakenE),
    .flagsE      (flagsE),
    .aluOutM     (aluOutM),
    .writeDataM  (writeDataM),
    .readDataM   (readDataM),
    .hz          (hz.datapath)
  );

  hazardUnit i_hazardUnit (
    .hz(hz.hazard)
  );

endmodule

//--- dv/armCoreTb.sv
`timescale 1ns/1ps

module armCoreTb;

  localparam logic [3:0] condEq = 4'h0;
  localparam logic [3:0] condNe = 4'h1;
  localparam logic [3:0] condAl = 4'hE;
  localparam logic [3:0] opAnd  = 4'b0000;
  localparam logic [3:0] opSub  = 4'b0010;
  localparam logic [3:0] opAdd  = 4'b0100;
  localparam logic [3:0] opCmp  = 4'b1010;
  localparam logic [3:0] opOrr  = 4'b1100;
  localparam logic [3:0] opMov  = 4'b1101;
  localparam int maxCycles = 200;
  localparam armPkg::word_t haltAddr = 32'h0000_00FC;

  logic          clk;
  logic          reset;
  armPkg::word_t pcF;
  armPkg::word_t instrF;
  logic          memWrite;
  armPkg::word_t aluOutM;
  armPkg::word_t writeDataM;
  armPkg::word_t readDataM;

  armPkg::word_t prog [0:63];
  armPkg::word_t dmem [0:63];
  int            progLen;
  armPkg::word_t logAddr [$];
  armPkg::word_t logData [$];
  int            logCycle [$];
  logic          logEnable;
  logic          halted;
  int            cycleCount;
  int            numChecks;
  int            numErrors;

  armCore i_armCore (
    .clk       (clk),
    .reset     (reset),
    .pcF       (pcF),
    .instrF    (instrF),
    .memWrite  (memWrite),
    .aluOutM   (aluOutM),
    .writeDataM(writeDataM),
    .readDataM (readDataM)
  );

  always #50 clk = ~clk;

  // Edges since reset release
  always @(posedge clk) begin
    if (reset) begin
      cycleCount <= 0;
    end else begin
      cycleCount <= cycleCount + 1;
    end
  end

  // Instruction and data memory models
  always @(negedge clk) begin
    if (logEnable && memWrite === 1'b1) begin
      dmem[aluOutM[7:2]] = writeDataM;
      if (aluOutM == haltAddr) begin
        halted    = 1'b1;
        logEnable = 1'b0;
      end else begin
        logAddr.push_back(aluOutM);
        logData.push_back(writeDataM);
        logCycle.push_back(cycleCount);
      end
    end
    instrF    = prog[pcF[7:2]];
    readDataM = dmem[aluOutM[7:2]];
  end

  function automatic armPkg::word_t dataProcReg(input logic [3:0] opcode, input logic s,
      input armPkg::regAddr_t rd, input armPkg::regAddr_t rn, input armPkg::regAddr_t rm);
    return {condAl, 2'b00, 1'b0, opcode, s, rn, rd, 8'h00, rm};
  endfunction

  function automatic armPkg::word_t dataProcImm(input logic [3:0] opcode, input logic s,
      input armPkg::regAddr_t rd, input armPkg::regAddr_t rn, input logic [3:0] rot,
      input logic [7:0] imm8);
    return {condAl, 2'b00, 1'b1, opcode, s, rn, rd, rot, imm8};
  endfunction

  // Pre-indexed word access, positive offset
  function automatic armPkg::word_t memWord(input logic load, input armPkg::regAddr_t rd,
      input armPkg::regAddr_t rn, input logic [11:0] offset);
    return {condAl, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, offset};
  endfunction

  // Target in words relative to PC+8 of the branch
  function automatic armPkg::word_t branchTo(input logic [3:0] cond, input int fromIdx,
      input int toIdx);
    int offset;
    offset = toIdx - fromIdx - 2;
    return {cond, 3'b101, 1'b0, offset[23:0]};
  endfunction

  function automatic armPkg::word_t rotateRight(input logic [7:0] imm8, input logic [3:0] rot);
    armPkg::word_t w;
    int            i;
    w = {24'h0, imm8};
    for (i = 0; i < 2 * rot; i++) begin
      w = {w[0], w[31:1]};
    end
    return w;
  endfunction

  task automatic emit(input armPkg::word_t instr);
    prog[progLen] = instr;
    progLen++;
  endtask

  // Unused program words are zero, which decodes as a bubble
  task automatic initMemories();
    int i;
    for (i = 0; i < 64; i++) begin
      prog[i] = '0;
      dmem[i] = 32'hD47A_0000 ^ (i * 4);
    end
    progLen = 0;
  endtask

  task automatic checkStore(input int idx, input armPkg::word_t expAddr,
      input armPkg::word_t expData);
    numChecks++;
    if (idx >= logAddr.size()) begin
      numErrors++;
      $display("Error: store number %0d never happened", idx);
    end else begin
      if (logAddr[idx] !== expAddr) begin
        numErrors++;
        $display("Fail aluOutM: expected %h, got %h", expAddr, logAddr[idx]);
      end
      if (logData[idx] !== expData) begin
        numErrors++;
        $display("Fail writeDataM: expected %h, got %h", expData, logData[idx]);
      end
    end
  endtask

  task automatic expectWord(input string name, input armPkg::word_t exp,
      input armPkg::word_t got);
    numChecks++;
    if (got !== exp) begin
      numErrors++;
      $display("Fail %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic expectLow(input string name, input logic got);
    numChecks++;
    if (got !== 1'b0) begin
      numErrors++;
      $display("Fail %s: expected 0, got %h", name, got);
    end
  endtask

  task automatic compareCount(input string name, input int exp, input int got);
    numChecks++;
    if (got != exp) begin
      numErrors++;
      $display("Fail %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic applyReset(input logic checkIdle);
    int i;
    @(negedge clk);
    reset     = 1'b1;
    logEnable = 1'b0;
    for (i = 0; i < 16; i++) begin
      @(negedge clk);
      if (checkIdle) begin
        expectLow("memWrite", memWrite);
        expectWord("pcF", 32'h0, pcF);
      end
    end
    reset = 1'b0;
  endtask

  task automatic runProgram();
    int i;
    logAddr.delete();
    logData.delete();
    logCycle.delete();
    halted = 1'b0;
    applyReset(1'b0);
    logEnable = 1'b1;
    for (i = 0; i < maxCycles && !halted; i++) begin
      @(posedge clk);
    end
    if (!halted) begin
      numErrors++;
      logEnable = 1'b0;
      $display("Error: no halt store to address 0xfc within %0d cycles", maxCycles);
    end
  endtask

  // A store sits at the start so a live pipeline during reset would show it
  task automatic testResetState();
    initMemories();
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h040));
    emit(dataProcImm(opMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    applyReset(1'b1);
  endtask

  task automatic testAluChain();
    armPkg::word_t a;
    armPkg::word_t b;
    armPkg::word_t sum;
    armPkg::word_t diff;
    armPkg::word_t andv;
    a = $urandom;
    b = $urandom;
    initMemories();
    dmem[32] = a;
    dmem[33] = b;
    emit(dataProcImm(opMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    emit(memWord(1'b1, 4'd1, 4'd0, 12'h080));
    emit(memWord(1'b1, 4'd2, 4'd0, 12'h084));
    emit(dataProcReg(opAdd, 1'b0, 4'd3, 4'd1, 4'd2));
    emit(dataProcReg(opSub, 1'b1, 4'd4, 4'd3, 4'd1));
    emit(dataProcReg(opAnd, 1'b0, 4'd5, 4'd4, 4'd3));
    emit(dataProcReg(opOrr, 1'b0, 4'd6, 4'd2, 4'd5));
    emit(memWord(1'b0, 4'd3, 4'd0, 12'h040));
    emit(memWord(1'b0, 4'd4, 4'd0, 12'h044));
    emit(memWord(1'b0, 4'd5, 4'd0, 12'h048));
    emit(memWord(1'b0, 4'd6, 4'd0, 12'h04C));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h0FC));
    runProgram();
    sum  = a + b;
    diff = sum - a;
    andv = diff & sum;
    compareCount("store count", 4, logAddr.size());
    checkStore(0, 32'h40, sum);
    checkStore(1, 32'h44, diff);
    checkStore(2, 32'h48, andv);
    checkStore(3, 32'h4C, b | andv);
  endtask

  task automatic testRotatedImm();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] d;
    a = $urandom;
    b = $urandom;
    c = $urandom;
    d = $urandom;
    initMemories();
    emit(dataProcImm(opMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    emit(dataProcImm(opMov, 1'b0, 4'd7, 4'd0, 4'd4, a));
    emit(dataProcImm(opMov, 1'b0, 4'd8, 4'd0, 4'd1, b));
    emit(dataProcImm(opAdd, 1'b0, 4'd9, 4'd7, 4'd15, c));
    emit(dataProcImm(opOrr, 1'b0, 4'd10, 4'd8, 4'd0, d));
    emit(memWord(1'b0, 4'd7, 4'd0, 12'h040));
    emit(memWord(1'b0, 4'd8, 4'd0, 12'h044));
    emit(memWord(1'b0, 4'd9, 4'd0, 12'h048));
    emit(memWord(1'b0, 4'd10, 4'd0, 12'h04C));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h0FC));
    runProgram();
    compareCount("store count", 4, logAddr.size());
    checkStore(0, 32'h40, rotateRight(a, 4'd4));
    checkStore(1, 32'h44, rotateRight(b, 4'd1));
    checkStore(2, 32'h48, rotateRight(a, 4'd4) + rotateRight(c, 4'd15));
    checkStore(3, 32'h4C, rotateRight(b, 4'd1) | {24'h0, d});
  endtask

  task automatic testLoadUse();
    armPkg::word_t v;
    logic [7:0]    k;
    v = $urandom;
    k = $urandom;
    initMemories();
    dmem[34] = v;
    emit(dataProcImm(opMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    emit(dataProcImm(opMov, 1'b0, 4'd1, 4'd0, 4'd0, k));
    emit(memWord(1'b1, 4'd2, 4'd0, 12'h088));
    emit(dataProcReg(opAdd, 1'b0, 4'd3, 4'd2, 4'd1));
    emit(memWord(1'b0, 4'd3, 4'd0, 12'h050));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h0FC));
    runProgram();
    compareCount("store count", 1, logAddr.size());
    checkStore(0, 32'h50, v + {24'h0, k});
    // Word 4 reaches Memory after edge 4+3 plus one bubble
    if (logCycle.size() > 0) begin
      compareCount("store cycle", 4 + 3 + 1, logCycle[0]);
    end
  endtask

  // Markers at 0x60..0x78 lie on skipped paths
  task automatic testBranches();
    armPkg::word_t a;
    armPkg::word_t b;
    a = $urandom;
    b = a ^ ($urandom | 32'h1);
    initMemories();
    dmem[36] = a;
    dmem[37] = a;
    dmem[38] = b;
    emit(dataProcImm(opMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'd0));
    emit(memWord(1'b1, 4'd1, 4'd0, 12'h090));
    emit(memWord(1'b1, 4'd2, 4'd0, 12'h094));
    emit(memWord(1'b1, 4'd3, 4'd0, 12'h098));
    emit(dataProcReg(opCmp, 1'b1, 4'd0, 4'd1, 4'd2));
    emit(branchTo(condEq, 5, 9));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h060));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h064));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h068));
    emit(memWord(1'b0, 4'd1, 4'd0, 12'h040));
    emit(dataProcReg(opCmp, 1'b1, 4'd0, 4'd1, 4'd3));
    emit(branchTo(condEq, 11, 15));
    emit(memWord(1'b0, 4'd3, 4'd0, 12'h044));
    emit(branchTo(condNe, 13, 17));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h06C));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h070));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h074));
    emit(memWord(1'b0, 4'd2, 4'd0, 12'h048));
    emit(branchTo(condAl, 18, 20));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h078));
    emit(memWord(1'b0, 4'd0, 4'd0, 12'h0FC));
    runProgram();
    compareCount("store count", 3, logAddr.size());
    checkStore(0, 32'h40, a);
    checkStore(1, 32'h44, b);
    checkStore(2, 32'h48, a);
  endtask

  initial begin
    void'($urandom(79));
    clk       = 1'b0;
    reset     = 1'b1;
    instrF    = '0;
    readDataM = '0;
    logEnable = 1'b0;
    halted    = 1'b0;
    numChecks = 0;
    numErrors = 0;
    initMemories();

    testResetState();
    testAluChain();
    testRotatedImm();
    testLoadUse();
    testBranches();

    $display("%0d checks, %0d errors", numChecks, numErrors);
    if (numErrors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+src
src/armPkg.sv
src/hazardIf.sv
src/regFile.sv
src/alu.sv
src/controller.sv
src/datapath.sv
src/hazardUnit.sv
src/armCore.sv
dv/armCoreTb.sv
